// ==== Makefile ====
# Verilator build, run, lint and clean for the memory start-up testbench

VERILATOR  ?= verilator
TOP        ?= mem_init_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/axi_init_mux.sv ====
/*
 * Start-up port mux. The memory port follows the fill engine until
 * init_done and the host port afterwards, the host is held off meanwhile
 */
`timescale 1ns/10ps
`default_nettype none

module axi_init_mux #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 64
) (
    input  logic                    init_done,

    // Host port
    input  logic [ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [DATA_WIDTH-1:0]   s_axi_wdata,
    input  logic [DATA_WIDTH/8-1:0] s_axi_wstrb,
    input  logic                    s_axi_wlast,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output mem_init_pkg::axi_resp_t s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  logic [ADDR_WIDTH-1:0]   s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output logic [DATA_WIDTH-1:0]   s_axi_rdata,
    output mem_init_pkg::axi_resp_t s_axi_rresp,
    output logic                    s_axi_rlast,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready,

    // Fill engine, write channels only
    input  logic [ADDR_WIDTH-1:0]   zf_awaddr,
    input  logic                    zf_awvalid,
    output logic                    zf_awready,
    input  logic [DATA_WIDTH-1:0]   zf_wdata,
    input  logic [DATA_WIDTH/8-1:0] zf_wstrb,
    input  logic                    zf_wlast,
    input  logic                    zf_wvalid,
    output logic                    zf_wready,
    output logic                    zf_bvalid,
    input  logic                    zf_bready,

    // Memory port
    output logic [ADDR_WIDTH-1:0]   m_axi_awaddr,
    output logic                    m_axi_awvalid,
    input  logic                    m_axi_awready,
    output logic [DATA_WIDTH-1:0]   m_axi_wdata,
    output logic [DATA_WIDTH/8-1:0] m_axi_wstrb,
    output logic                    m_axi_wlast,
    output logic                    m_axi_wvalid,
    input  logic                    m_axi_wready,
    input  mem_init_pkg::axi_resp_t m_axi_bresp,
    input  logic                    m_axi_bvalid,
    output logic                    m_axi_bready,
    output logic [ADDR_WIDTH-1:0]   m_axi_araddr,
    output logic                    m_axi_arvalid,
    input  logic                    m_axi_arready,
    input  logic [DATA_WIDTH-1:0]   m_axi_rdata,
    input  mem_init_pkg::axi_resp_t m_axi_rresp,
    input  logic                    m_axi_rlast,
    input  logic                    m_axi_rvalid,
    output logic                    m_axi_rready
);

    assign m_axi_awaddr  = init_done ? s_axi_awaddr  : zf_awaddr;
    assign m_axi_awvalid = init_done ? s_axi_awvalid : zf_awvalid;
    assign s_axi_awready = init_done && m_axi_awready;
    assign zf_awready    = !init_done && m_axi_awready;

    assign m_axi_wdata  = init_done ? s_axi_wdata  : zf_wdata;
    assign m_axi_wstrb  = init_done ? s_axi_wstrb  : zf_wstrb;
    assign m_axi_wlast  = init_done ? s_axi_wlast  : zf_wlast;
    assign m_axi_wvalid = init_done ? s_axi_wvalid : zf_wvalid;
    assign s_axi_wready = init_done && m_axi_wready;
    assign zf_wready    = !init_done && m_axi_wready;

    // Responses go to whichever side owns the port
    assign s_axi_bresp  = init_done ? m_axi_bresp : mem_init_pkg::RESP_OKAY;
    assign s_axi_bvalid = init_done && m_axi_bvalid;
    assign zf_bvalid    = !init_done && m_axi_bvalid;
    assign m_axi_bready = init_done ? s_axi_bready : zf_bready;

    // The engine never reads, so AR and R sit idle during the fill
    assign m_axi_araddr  = init_done ? s_axi_araddr : '0;
    assign m_axi_arvalid = init_done && s_axi_arvalid;
    assign s_axi_arready = init_done && m_axi_arready;
    assign s_axi_rdata   = init_done ? m_axi_rdata : '0;
    assign s_axi_rresp   = init_done ? m_axi_rresp : mem_init_pkg::RESP_OKAY;
    assign s_axi_rlast   = init_done && m_axi_rlast;
    assign s_axi_rvalid  = init_done && m_axi_rvalid;
    assign m_axi_rready  = init_done && s_axi_rready;

endmodule

`default_nettype wire

// ==== design/axi_sram_slave.sv ====
/*
 * Single-beat AXI4 memory slave with byte strobes, a write response
 * queue, one read in flight and SLVERR for addresses past the array
 */
`timescale 1ns/10ps
`default_nettype none

module axi_sram_slave #(
    parameter int ADDR_WIDTH = 16,
    parameter int DATA_WIDTH = 64,
    parameter int MEM_WORDS  = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [ADDR_WIDTH-1:0]   m_axi_awaddr,
    input  logic                    m_axi_awvalid,
    output logic                    m_axi_awready,
    input  logic [DATA_WIDTH-1:0]   m_axi_wdata,
    input  logic [DATA_WIDTH/8-1:0] m_axi_wstrb,
    input  logic                    m_axi_wlast,
    input  logic                    m_axi_wvalid,
    output logic                    m_axi_wready,
    output mem_init_pkg::axi_resp_t m_axi_bresp,
    output logic                    m_axi_bvalid,
    input  logic                    m_axi_bready,
    input  logic [ADDR_WIDTH-1:0]   m_axi_araddr,
    input  logic                    m_axi_arvalid,
    output logic                    m_axi_arready,
    output logic [DATA_WIDTH-1:0]   m_axi_rdata,
    output mem_init_pkg::axi_resp_t m_axi_rresp,
    output logic                    m_axi_rlast,
    output logic                    m_axi_rvalid,
    input  logic                    m_axi_rready
);

    localparam int STRB_W  = DATA_WIDTH / 8;
    localparam int OFFS_W  = $clog2(STRB_W);
    localparam int IDX_W   = $clog2(MEM_WORDS);
    localparam int Q_DEPTH = 8;
    localparam int Q_PTR_W = $clog2(Q_DEPTH);
    localparam logic [ADDR_WIDTH:0] ADDR_LIMIT = (ADDR_WIDTH + 1)'(MEM_WORDS * STRB_W);

    logic [DATA_WIDTH-1:0]   mem [MEM_WORDS];
    mem_init_pkg::axi_resp_t resp_q [Q_DEPTH];
    logic [Q_PTR_W-1:0]      q_wr_ptr;
    logic [Q_PTR_W-1:0]      q_rd_ptr;
    logic [Q_PTR_W:0]        q_count;
    logic                    q_full;
    logic                    wr_fire;
    logic                    wr_ok;
    logic                    b_pop;
    logic                    rd_fire;
    logic                    rd_ok;
    logic [IDX_W-1:0]        aw_idx;
    logic [IDX_W-1:0]        ar_idx;

    assign aw_idx = m_axi_awaddr[OFFS_W +: IDX_W];
    assign ar_idx = m_axi_araddr[OFFS_W +: IDX_W];

    // AW and W are accepted together, and only with room for the response
    assign q_full        = (q_count == (Q_PTR_W + 1)'(Q_DEPTH));
    assign wr_fire       = m_axi_awvalid && m_axi_wvalid && !q_full;
    assign m_axi_awready = wr_fire;
    assign m_axi_wready  = wr_fire;

    // A beat without wlast cannot be a single-beat burst
    assign wr_ok = ({1'b0, m_axi_awaddr} < ADDR_LIMIT) && m_axi_wlast;

    always_ff @(posedge clk) begin
        if (wr_fire && wr_ok) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (m_axi_wstrb[b]) begin
                    mem[aw_idx][8*b +: 8] <= m_axi_wdata[8*b +: 8];
                end
            end
        end
        if (wr_fire) begin
            resp_q[q_wr_ptr] <= wr_ok ? mem_init_pkg::RESP_OKAY : mem_init_pkg::RESP_SLVERR;
        end
    end

    assign b_pop        = m_axi_bvalid && m_axi_bready;
    assign m_axi_bvalid = (q_count != '0);
    assign m_axi_bresp  = resp_q[q_rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (wr_fire) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (b_pop) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            case ({wr_fire, b_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // One read at a time, the next address waits for the R handshake
    assign m_axi_arready = !m_axi_rvalid;
    assign rd_fire       = m_axi_arvalid && m_axi_arready;
    assign rd_ok         = ({1'b0, m_axi_araddr} < ADDR_LIMIT);
    assign m_axi_rlast   = m_axi_rvalid;

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            m_axi_rdata <= rd_ok ? mem[ar_idx] : '0;
            m_axi_rresp <= rd_ok ? mem_init_pkg::RESP_OKAY : mem_init_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_axi_rvalid <= 1'b0;
        end else if (rd_fire) begin
            m_axi_rvalid <= 1'b1;
        end else if (m_axi_rready) begin
            m_axi_rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_init_pkg.sv ====
/*
 * Memory start-up subsystem shared definitions: default widths and
 * depths, the AXI response codes and the fill FSM states
 */
`default_nettype none

package mem_init_pkg;

    // Byte address width and data width of every AXI4 port
    localparam int ADDR_WIDTH_DEF = 16;
    localparam int DATA_WIDTH_DEF = 64;

    // Depth of the memory in words
    localparam int MEM_WORDS_DEF = 256;

    // Upper bound on zeroing writes in flight, the engine stays one below it
    localparam int MAX_OUTSTANDING_DEF = 8;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } axi_resp_t;

    typedef enum logic [1:0] {
        ZF_IDLE = 2'd0,
        ZF_ADDR = 2'd1,
        ZF_DATA = 2'd2
    } zero_state_t;

endpackage

`default_nettype wire

// ==== design/mem_init_top.sv ====
/*
 * Memory start-up top level: zero fill engine and start-up mux
 * in front of the on-chip AXI4 memory
 */
`timescale 1ns/10ps
`default_nettype none

module mem_init_top #(
    parameter int ADDR_WIDTH      = mem_init_pkg::ADDR_WIDTH_DEF,
    parameter int DATA_WIDTH      = mem_init_pkg::DATA_WIDTH_DEF,
    parameter int MEM_WORDS       = mem_init_pkg::MEM_WORDS_DEF,
    parameter int MAX_OUTSTANDING = mem_init_pkg::MAX_OUTSTANDING_DEF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    calib_done,
    output logic                    init_done,

    input  logic [ADDR_WIDTH-1:0]   s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [DATA_WIDTH-1:0]   s_axi_wdata,
    input  logic [DATA_WIDTH/8-1:0] s_axi_wstrb,
    input  logic                    s_axi_wlast,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  logic [ADDR_WIDTH-1:0]   s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output logic [DATA_WIDTH-1:0]   s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rlast,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready
);

    // Engine to mux
    logic [ADDR_WIDTH-1:0]   zf_awaddr;
    logic                    zf_awvalid;
    logic                    zf_awready;
    logic [DATA_WIDTH-1:0]   zf_wdata;
    logic [DATA_WIDTH/8-1:0] zf_wstrb;
    logic                    zf_wlast;
    logic                    zf_wvalid;
    logic                    zf_wready;
    logic                    zf_bvalid;
    logic                    zf_bready;

    // Mux to memory
    logic [ADDR_WIDTH-1:0]   m_axi_awaddr;
    logic                    m_axi_awvalid;
    logic                    m_axi_awready;
    logic [DATA_WIDTH-1:0]   m_axi_wdata;
    logic [DATA_WIDTH/8-1:0] m_axi_wstrb;
    logic                    m_axi_wlast;
    logic                    m_axi_wvalid;
    logic                    m_axi_wready;
    mem_init_pkg::axi_resp_t m_axi_bresp;
    logic                    m_axi_bvalid;
    logic                    m_axi_bready;
    logic [ADDR_WIDTH-1:0]   m_axi_araddr;
    logic                    m_axi_arvalid;
    logic                    m_axi_arready;
    logic [DATA_WIDTH-1:0]   m_axi_rdata;
    mem_init_pkg::axi_resp_t m_axi_rresp;
    logic                    m_axi_rlast;
    logic                    m_axi_rvalid;
    logic                    m_axi_rready;

    zero_fill_engine #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DATA_WIDTH     (DATA_WIDTH),
        .MEM_WORDS      (MEM_WORDS),
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) u_engine (.*);

    axi_init_mux #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_mux (.*);

    axi_sram_slave #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH),
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (.*);

endmodule

`default_nettype wire

// ==== design/zero_fill_engine.sv ====
/*
 * Zero fill engine. Once calibration completes it writes zero to every
 * memory word with single-beat AXI4 writes and flags done when all are answered
 */
`timescale 1ns/10ps
`default_nettype none

module zero_fill_engine #(
    parameter int ADDR_WIDTH      = 16,
    parameter int DATA_WIDTH      = 64,
    parameter int MEM_WORDS       = 256,
    parameter int MAX_OUTSTANDING = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    calib_done,
    output logic                    init_done,

    output logic [ADDR_WIDTH-1:0]   zf_awaddr,
    output logic                    zf_awvalid,
    input  logic                    zf_awready,

    output logic [DATA_WIDTH-1:0]   zf_wdata,
    output logic [DATA_WIDTH/8-1:0] zf_wstrb,
    output logic                    zf_wlast,
    output logic                    zf_wvalid,
    input  logic                    zf_wready,

    input  logic                    zf_bvalid,
    output logic                    zf_bready
);

    localparam int OFFS_W = $clog2(DATA_WIDTH / 8);
    localparam int CNT_W  = $clog2(MEM_WORDS + 1);
    localparam int OST_W  = $clog2(MAX_OUTSTANDING + 1);

    mem_init_pkg::zero_state_t state, state_next;
    logic              awvalid_next;
    logic              wvalid_next;
    logic [CNT_W-1:0]  req_sent;
    logic [CNT_W-1:0]  resp_got;
    logic [OST_W-1:0]  outstanding;
    logic              req_val;
    logic              req_go;
    logic              resp_go;
    logic              last_resp;

    // A new request may start only below the outstanding limit
    assign req_val = calib_done
                   && (req_sent < CNT_W'(MEM_WORDS))
                   && (outstanding < OST_W'(MAX_OUTSTANDING - 1));

    // Every B response follows one of our own AW transfers
    assign zf_bready = calib_done && (outstanding != '0);

    assign req_go    = zf_awvalid && zf_awready;
    assign resp_go   = zf_bvalid && zf_bready;
    assign last_resp = resp_go && (resp_got == CNT_W'(MEM_WORDS - 1))
                     && (req_sent == CNT_W'(MEM_WORDS));

    assign zf_awaddr = ADDR_WIDTH'(req_sent) << OFFS_W;
    assign zf_wdata  = '0;
    assign zf_wstrb  = '1;
    assign zf_wlast  = 1'b1;

    always_comb begin
        state_next   = state;
        awvalid_next = zf_awvalid && !zf_awready;
        wvalid_next  = zf_wvalid && !zf_wready;
        case (state)
            mem_init_pkg::ZF_IDLE: begin
                if (calib_done && !init_done) begin
                    state_next = mem_init_pkg::ZF_ADDR;
                end
            end
            mem_init_pkg::ZF_ADDR: begin
                // The memory may wait for both valids, so AW and W are offered together
                if (!zf_awvalid && req_val) begin
                    awvalid_next = 1'b1;
                    wvalid_next  = 1'b1;
                end
                if (init_done) begin
                    state_next = mem_init_pkg::ZF_IDLE;
                end else if (req_go) begin
                    state_next = mem_init_pkg::ZF_DATA;
                end
            end
            mem_init_pkg::ZF_DATA: begin
                // The address is taken, the data beat may still wait for wready
                if (!zf_wvalid || zf_wready) begin
                    state_next = mem_init_pkg::ZF_ADDR;
                end
            end
            default: state_next = mem_init_pkg::ZF_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= mem_init_pkg::ZF_IDLE;
            zf_awvalid  <= 1'b0;
            zf_wvalid   <= 1'b0;
            req_sent    <= '0;
            resp_got    <= '0;
            outstanding <= '0;
            init_done   <= 1'b0;
        end else begin
            state      <= state_next;
            zf_awvalid <= awvalid_next;
            zf_wvalid  <= wvalid_next;
            req_sent   <= req_sent + CNT_W'(req_go);
            resp_got   <= resp_got + CNT_W'(resp_go);
            case ({req_go, resp_go})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
            // Sticky until the next reset
            if (last_resp) begin
                init_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/mem_init_pkg.sv
design/zero_fill_engine.sv
design/axi_init_mux.sv
design/axi_sram_slave.sv
design/mem_init_top.sv
verif/mem_init_asserts.sv
verif/tb_clock_gen.sv
verif/mem_init_tb.sv

// ==== verif/mem_init_asserts.sv ====
/*
 * Protocol and start-up assertions for the memory start-up top level
 */
`timescale 1ns/10ps
`default_nettype none

module mem_init_asserts #(
    parameter int ADDR_WIDTH      = 16,
    parameter int DATA_WIDTH      = 64,
    parameter int MAX_OUTSTANDING = 8
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    init_done,
    input logic                    s_axi_awready,
    input logic                    s_axi_wready,
    input logic                    s_axi_arready,
    input logic                    s_axi_bvalid,
    input logic                    s_axi_rvalid,
    input logic [ADDR_WIDTH-1:0]   m_axi_awaddr,
    input logic                    m_axi_awvalid,
    input logic                    m_axi_awready,
    input logic [DATA_WIDTH-1:0]   m_axi_wdata,
    input logic [DATA_WIDTH/8-1:0] m_axi_wstrb,
    input logic                    m_axi_wlast,
    input logic                    m_axi_wvalid,
    input logic                    m_axi_wready,
    input mem_init_pkg::axi_resp_t m_axi_bresp,
    input logic                    m_axi_bvalid,
    input logic                    m_axi_bready,
    input logic [DATA_WIDTH-1:0]   m_axi_rdata,
    input mem_init_pkg::axi_resp_t m_axi_rresp,
    input logic                    m_axi_rvalid,
    input logic                    m_axi_rready,
    input mem_init_pkg::zero_state_t fill_state
);

    int assert_errors = 0;
    int unanswered;

    // Writes accepted by the memory whose B response has not been taken yet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unanswered <= 0;
        end else begin
            unanswered <= unanswered + int'(m_axi_awvalid && m_axi_awready)
                                     - int'(m_axi_bvalid && m_axi_bready);
        end
    end

    a_host_held_off: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> !(s_axi_awready || s_axi_wready || s_axi_arready
                         || s_axi_bvalid || s_axi_rvalid))
        else begin
            assert_errors++;
            $error("host port handshake seen before init_done");
        end

    a_done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |=> init_done)
        else begin
            assert_errors++;
            $error("init_done dropped without a reset");
        end

    a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        !init_done |-> unanswered <= MAX_OUTSTANDING - 1)
        else begin
            assert_errors++;
            $error("too many fill writes without a response");
        end

    a_idle_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        init_done |=> fill_state == mem_init_pkg::ZF_IDLE)
        else begin
            assert_errors++;
            $error("fill engine still active after init_done");
        end

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awaddr))
        else begin
            assert_errors++;
            $error("AW channel changed before awready");
        end

    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_wvalid && !m_axi_wready
        |=> m_axi_wvalid && $stable({m_axi_wdata, m_axi_wstrb, m_axi_wlast}))
        else begin
            assert_errors++;
            $error("W channel changed before wready");
        end

    a_b_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_bvalid && !m_axi_bready |=> m_axi_bvalid && $stable(m_axi_bresp))
        else begin
            assert_errors++;
            $error("B channel changed before bready");
        end

    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_rvalid && !m_axi_rready
        |=> m_axi_rvalid && $stable({m_axi_rdata, m_axi_rresp}))
        else begin
            assert_errors++;
            $error("R channel changed before rready");
        end

endmodule

bind mem_init_top mem_init_asserts #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
) u_asserts (.*, .fill_state(u_engine.state));

`default_nettype wire

// ==== verif/mem_init_tb.sv ====
/*
 * Testbench for the memory start-up subsystem. Host AXI4 traffic
 * around two zero fills, with a watchdog and a closing status line
 */
`timescale 1ns/10ps
`default_nettype none

module mem_init_tb;

    localparam int ADDR_W      = mem_init_pkg::ADDR_WIDTH_DEF;
    localparam int DATA_W      = mem_init_pkg::DATA_WIDTH_DEF;
    localparam int WORDS       = mem_init_pkg::MEM_WORDS_DEF;
    localparam int MAX_OUT     = mem_init_pkg::MAX_OUTSTANDING_DEF;
    localparam int STRB_W      = DATA_W / 8;
    localparam int DRIVE_DLY   = 1;
    // Two fills at a slow pace of 40 cycles per word, plus host traffic
    localparam int WATCHDOG_CYCLES = 40 * WORDS * 2 + 2000;

    logic              clk;
    logic              rst_n;
    logic              rst_req;
    logic              calib_done;
    logic              init_done;
    logic [ADDR_W-1:0] s_axi_awaddr;
    logic              s_axi_awvalid;
    logic              s_axi_awready;
    logic [DATA_W-1:0] s_axi_wdata;
    logic [STRB_W-1:0] s_axi_wstrb;
    logic              s_axi_wlast;
    logic              s_axi_wvalid;
    logic              s_axi_wready;
    logic [1:0]        s_axi_bresp;
    logic              s_axi_bvalid;
    logic              s_axi_bready;
    logic [ADDR_W-1:0] s_axi_araddr;
    logic              s_axi_arvalid;
    logic              s_axi_arready;
    logic [DATA_W-1:0] s_axi_rdata;
    logic [1:0]        s_axi_rresp;
    logic              s_axi_rlast;
    logic              s_axi_rvalid;
    logic              s_axi_rready;

    int data_errors = 0;
    int resp_errors = 0;

    tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(2)) u_clk_gen (
        .rst_req(rst_req),
        .clk    (clk),
        .rst_n  (rst_n)
    );

    mem_init_top #(
        .ADDR_WIDTH     (ADDR_W),
        .DATA_WIDTH     (DATA_W),
        .MEM_WORDS      (WORDS),
        .MAX_OUTSTANDING(MAX_OUT)
    ) UUT (.*);

    // Inputs change a little after the rising edge, outputs are read at the falling edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    function automatic logic [ADDR_W-1:0] word_addr(input int idx);
        return ADDR_W'(idx * STRB_W);
    endfunction

    // Bytes with a low strobe keep the zero left by the fill
    function automatic logic [DATA_W-1:0] strobe_merge(input logic [DATA_W-1:0] data,
                                                        input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] result;
        result = '0;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb, output logic [1:0] resp);
        logic aw_fire;
        logic w_fire;
        logic b_fire;
        s_axi_awaddr = addr;
        s_axi_wdata  = data;
        s_axi_wstrb  = strb;
        // One channel may lead the other by a few idle cycles
        if ($urandom_range(1) == 0) begin
            s_axi_awvalid = 1'b1;
        end else begin
            s_axi_wvalid = 1'b1;
        end
        repeat ($urandom_range(2)) next_cycle();
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        while (s_axi_awvalid || s_axi_wvalid) begin
            @(negedge clk);
            aw_fire = s_axi_awvalid && s_axi_awready;
            w_fire  = s_axi_wvalid && s_axi_wready;
            next_cycle();
            if (aw_fire) begin
                s_axi_awvalid = 1'b0;
            end
            if (w_fire) begin
                s_axi_wvalid = 1'b0;
            end
        end
        repeat ($urandom_range(2)) next_cycle();
        s_axi_bready = 1'b1;
        do begin
            @(negedge clk);
            b_fire = s_axi_bvalid;
            resp   = s_axi_bresp;
            next_cycle();
        end while (!b_fire);
        s_axi_bready = 1'b0;
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                             output logic [1:0] resp);
        logic fire;
        logic last;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        do begin
            @(negedge clk);
            fire = s_axi_arready;
            next_cycle();
        end while (!fire);
        s_axi_arvalid = 1'b0;
        repeat ($urandom_range(2)) next_cycle();
        s_axi_rready  = 1'b1;
        do begin
            @(negedge clk);
            fire = s_axi_rvalid;
            data = s_axi_rdata;
            resp = s_axi_rresp;
            last = s_axi_rlast;
            next_cycle();
        end while (!fire);
        s_axi_rready = 1'b0;
        assert (last === 1'b1) else begin
            resp_errors++;
            $display("Error at %0t ns: rlast is low on the read at 0x%0h", $time, addr);
        end
    endtask

    task automatic check_resp(input string what, input logic [ADDR_W-1:0] addr,
                              input logic [1:0] got, input logic [1:0] exp);
        assert (got === exp) else begin
            resp_errors++;
            $display("Error at %0t ns: %s response at 0x%0h is %0d, expected %0d",
                     $time, what, addr, got, exp);
        end
    endtask

    task automatic check_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp, input logic [1:0] got_resp,
                              input logic [1:0] exp_resp);
        assert (got === exp) else begin
            data_errors++;
            $display("Error at %0t ns: read at 0x%0h returned 0x%0h, expected 0x%0h",
                     $time, addr, got, exp);
        end
        check_resp("read", addr, got_resp, exp_resp);
    endtask

    task automatic wait_for_init();
        while (!init_done) begin
            next_cycle();
        end
    endtask

    initial begin
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] pattern;
        logic [STRB_W-1:0] strb;
        logic [ADDR_W-1:0] addr;
        logic [1:0]        resp;
        int                idx;

        void'($urandom(32'hfbeb));
        rst_req       = 1'b0;
        calib_done    = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wlast   = 1'b1;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        @(posedge rst_n);
        next_cycle();

        // Host pushes on every channel before calibration and early in the fill
        s_axi_wstrb   = '1;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        s_axi_arvalid = 1'b1;
        s_axi_bready  = 1'b1;
        s_axi_rready  = 1'b1;
        repeat (8) next_cycle();
        calib_done = 1'b1;
        repeat (16) next_cycle();
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_arvalid = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_rready  = 1'b0;
        wait_for_init();

        // Every word gets a nonzero pattern carrying its index, so a missed word reads back
        for (int i = 0; i < WORDS; i++) begin
            pattern = {32'(i + 1), $urandom};
            host_write(word_addr(i), pattern, '1, resp);
            check_resp("write", word_addr(i), resp, mem_init_pkg::RESP_OKAY);
            repeat ($urandom_range(3)) next_cycle();
        end

        // The array keeps its data through reset, so only the second fill clears it
        calib_done = 1'b0;
        rst_req    = 1'b1;
        repeat (2) next_cycle();
        rst_req = 1'b0;
        repeat (4) next_cycle();
        calib_done = 1'b1;
        wait_for_init();

        for (int i = 0; i < WORDS; i++) begin
            host_read(word_addr(i), rdata, resp);
            check_read(word_addr(i), rdata, '0, resp, mem_init_pkg::RESP_OKAY);
        end

        idx     = int'($urandom_range(WORDS - 1));
        pattern = {$urandom, $urandom};
        strb    = STRB_W'($urandom);
        host_write(word_addr(idx), pattern, strb, resp);
        check_resp("write", word_addr(idx), resp, mem_init_pkg::RESP_OKAY);
        host_read(word_addr(idx), rdata, resp);
        check_read(word_addr(idx), rdata, strobe_merge(pattern, strb), resp,
                   mem_init_pkg::RESP_OKAY);

        addr = ADDR_W'((WORDS + int'($urandom_range(WORDS))) * STRB_W);
        host_write(addr, {$urandom, $urandom}, '1, resp);
        check_resp("write", addr, resp, mem_init_pkg::RESP_SLVERR);
        host_read(addr, rdata, resp);
        check_read(addr, rdata, '0, resp, mem_init_pkg::RESP_SLVERR);

        repeat (4) next_cycle();
        $display("Error counts: data %0d, response %0d, assertion %0d",
                 data_errors, resp_errors, UUT.u_asserts.assert_errors);
        if (data_errors == 0 && resp_errors == 0 && UUT.u_asserts.assert_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles, init_done is %0b",
                 WATCHDOG_CYCLES, init_done);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
/*
 * Testbench clock and reset. Free-running clock, power-on reset,
 * and a request input for later reset pulses
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    input  logic rst_req,
    output logic clk,
    output logic rst_n
);

    logic por_n;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        por_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        por_n = 1'b1;
    end

    // Reset stays asserted as long as the testbench requests it
    assign rst_n = por_n && !rst_req;

endmodule

`default_nettype wire
